/* compile.f */
+incdir+source
source/arb_pkg.sv
source/pn_seq_gen.sv
source/prio_pick.sv
source/rr_pick.sv
source/grant_select.sv
source/arb_top.sv
verif/tb_clk_gen.sv
verif/arb_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the arbiter testbench with Verilator.
# Exits nonzero when a build step fails or the testbench reports failure.

cd "$(dirname "$0")" || exit 1

TOP=arb_tb
OBJ_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

rm -rf "$OBJ_DIR" "$LOG"

verilator --binary --timing -j 0 --top-module "$TOP" --Mdir "$OBJ_DIR" \
  -o "V$TOP" -f compile.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  echo "Result: testbench reported failure"
  exit 1
fi

if ! grep -q "Simulation finished: PASS" "$LOG"; then
  echo "Result: no final status line in $LOG"
  exit 1
fi

echo "Result: testbench passed"
exit 0

/* source/arb_cfg.svh */
//********************************************************************
// Arbiter configuration
// Requester count, index and type widths, and the arbitration
// type codes decoded by the grant selector
//********************************************************************
`ifndef ARB_CFG_SVH
`define ARB_CFG_SVH

// Four requesters only, the pickers depend on it
`define ARB_NUM_REQ    4
`define ARB_IDX_W      2
`define ARB_TYPE_W     3

// Fixed priority, code names the top requester
`define ARB_MODE_P0    3'd0
`define ARB_MODE_P1    3'd1
`define ARB_MODE_P2    3'd2
`define ARB_MODE_P3    3'd3

// Rotating schemes
`define ARB_MODE_RR    3'd4
`define ARB_MODE_RAND  3'd5

`endif

/* source/arb_pkg.sv */
//********************************************************************
// Arbiter types
// Vector types shared by the arbiter RTL and its testbench
//********************************************************************
`include "arb_cfg.svh"

package arb_pkg;

  // One bit per requester, used for both requests and grants
  typedef logic [`ARB_NUM_REQ-1:0] req_vec_t;

  // Requester index
  typedef logic [`ARB_IDX_W-1:0]   req_idx_t;

  // Arbitration scheme selector
  typedef logic [`ARB_TYPE_W-1:0]  arb_type_t;

endpackage

/* source/arb_top.sv */
//********************************************************************
// Four-requester bus arbiter
// Registers one grant per clock under a selectable fixed priority,
// round-robin or pseudo-random scheme
//********************************************************************
`timescale 1ns/10ps

module arb_top (
  input  logic               clk,
  input  logic               rst_n,
  input  arb_pkg::req_vec_t  req,
  input  arb_pkg::arb_type_t arb_type,
  output arb_pkg::req_vec_t  gnt
);

  import arb_pkg::*;

  req_idx_t rand_sel;  // Random scheme start index

  pn_seq_gen u_pn_seq_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_sel (rand_sel)
  );

  grant_select u_grant_select (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .arb_type (arb_type),
    .rand_sel (rand_sel),
    .gnt      (gnt)
  );

endmodule

/* source/grant_select.sv */
//********************************************************************
// Grant selector
// Runs the fixed, random and round-robin pickers on the sampled
// requests, selects one result by arbitration type and registers it.
// Codes 6 and 7 give no grant
//********************************************************************
`timescale 1ns/10ps
`include "arb_cfg.svh"

module grant_select (
  input  logic               clk,
  input  logic               rst_n,
  input  arb_pkg::req_vec_t  req,
  input  arb_pkg::arb_type_t arb_type,
  input  arb_pkg::req_idx_t  rand_sel,
  output arb_pkg::req_vec_t  gnt
);

  import arb_pkg::*;

  req_idx_t fixed_top;
  req_idx_t rr_ptr;
  req_vec_t fixed_gnt;
  req_vec_t rand_gnt;
  req_vec_t rr_gnt;
  req_vec_t gnt_next;
  req_vec_t gnt_q;

  // Codes 0..3 carry the top requester in the low bits
  assign fixed_top = arb_type[`ARB_IDX_W-1:0];

  prio_pick u_fixed_pick (
    .req     (req),
    .top_idx (fixed_top),
    .pick    (fixed_gnt)
  );

  prio_pick u_rand_pick (
    .req     (req),
    .top_idx (rand_sel),
    .pick    (rand_gnt)
  );

  rr_pick u_rr_pick (
    .req      (req),
    .last_idx (rr_ptr),
    .pick     (rr_gnt)
  );

  // Encode current grant, idle counts as index 0
  always_comb begin
    rr_ptr = '0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (gnt_q[i]) begin
        rr_ptr = req_idx_t'(i);
      end
    end
  end

  always_comb begin
    case (arb_type)
      `ARB_MODE_P0,
      `ARB_MODE_P1,
      `ARB_MODE_P2,
      `ARB_MODE_P3:   gnt_next = fixed_gnt;
      `ARB_MODE_RR:   gnt_next = rr_gnt;
      `ARB_MODE_RAND: gnt_next = rand_gnt;
      default:        gnt_next = '0;  // Unused codes
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_q <= '0;
    end else begin
      gnt_q <= gnt_next;  // One cycle after sampling
    end
  end

  assign gnt = gnt_q;

endmodule

/* source/pn_seq_gen.sv */
//********************************************************************
// Pseudo-random sequence generator
// Three-flop maximal-length LFSR, period 7, seeded nonzero by reset.
// The top two bits name the first requester of the random scheme
//********************************************************************
`timescale 1ns/10ps

module pn_seq_gen (
  input  logic              clk,
  input  logic              rst_n,
  output arb_pkg::req_idx_t rand_sel
);

  import arb_pkg::*;

  logic s1;
  logic s2;
  logic s3;
  logic fb;

  assign fb = s1 ^ s3;  // Taps on s1 and s3

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= 1'b1;  // All-zero state would lock up
      s2 <= 1'b0;
      s3 <= 1'b0;
    end else begin
      s1 <= fb;
      s2 <= s1;
      s3 <= s2;
    end
  end

  // Free running, steps on every clock
  assign rand_sel = req_idx_t'({s3, s2});

endmodule

/* source/prio_pick.sv */
//********************************************************************
// Priority picker
// Grants the requester named by top_idx when it requests, otherwise
// the lowest requesting index. One-hot result, zero when idle
//********************************************************************
`timescale 1ns/10ps

module prio_pick (
  input  arb_pkg::req_vec_t req,
  input  arb_pkg::req_idx_t top_idx,
  output arb_pkg::req_vec_t pick
);

  import arb_pkg::*;

  req_vec_t top_hot;
  req_vec_t low_hot;
  logic     top_req;

  // One-hot of the favoured requester
  assign top_hot = req_vec_t'(1) << top_idx;
  assign top_req = req[top_idx];

  // Isolate lowest set bit
  assign low_hot = req & (~req + req_vec_t'(1));

  always_comb begin
    if (top_req) begin
      pick = top_hot;
    end else begin
      pick = low_hot;  // Zero when req is zero
    end
  end

endmodule

/* source/rr_pick.sv */
//********************************************************************
// Round-robin picker
// Search starts one index after last_idx and wraps around, so the
// current holder is checked last and a lone requester keeps its grant
//********************************************************************
`timescale 1ns/10ps
`include "arb_cfg.svh"

module rr_pick (
  input  arb_pkg::req_vec_t req,
  input  arb_pkg::req_idx_t last_idx,
  output arb_pkg::req_vec_t pick
);

  import arb_pkg::*;

  req_idx_t                  start_idx;
  logic [2*`ARB_NUM_REQ-1:0] req_dbl;
  logic [2*`ARB_NUM_REQ-1:0] rot_dbl;
  logic [2*`ARB_NUM_REQ-1:0] back_dbl;
  req_vec_t                  req_rot;
  req_vec_t                  low_rot;

  assign start_idx = last_idx + req_idx_t'(1);  // 3 wraps to 0

  // Rotate so start_idx lands on bit 0
  assign req_dbl = {req, req};
  assign rot_dbl = req_dbl >> start_idx;
  assign req_rot = req_vec_t'(rot_dbl);

  // First requester in rotated order
  assign low_rot = req_rot & (~req_rot + req_vec_t'(1));

  // Rotate the winner back to its own position
  assign back_dbl = {low_rot, low_rot} << start_idx;
  assign pick     = req_vec_t'(back_dbl >> `ARB_NUM_REQ);

endmodule

/* verif/arb_tb.sv */
//********************************************************************
// Arbiter testbench
// Applies tables of arbitration type and request patterns to the
// arbiter, one row per clock, and checks every registered grant
// against a reference model of the four schemes
//********************************************************************
`timescale 1ns/10ps
`include "arb_cfg.svh"

module arb_tb;

  import arb_pkg::*;

  typedef struct packed {
    arb_type_t t;
    req_vec_t  r;
    req_vec_t  e;
    logic      use_model;  // Expected value comes from the model
  } row_t;

  logic        clk;
  logic        rst_n;
  req_vec_t    req;
  arb_type_t   arb_type;
  req_vec_t    gnt;

  row_t        rows[$];
  req_vec_t    last_gnt;  // Previous expected grant
  logic        m_s1;
  logic        m_s2;
  logic        m_s3;
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          fail_cnt;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  arb_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .arb_type (arb_type),
    .gnt      (gnt)
  );

  // Reference LFSR, seeded by reset and stepped on every edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_s1 <= 1'b1;
      m_s2 <= 1'b0;
      m_s3 <= 1'b0;
    end else begin
      m_s1 <= m_s1 ^ m_s3;
      m_s2 <= m_s1;
      m_s3 <= m_s2;
    end
  end

  // Named requester first, else lowest requesting index
  function automatic req_vec_t prio_expect(input int top, input req_vec_t r);
    req_vec_t g;
    g = '0;
    if (r[top]) begin
      g[top] = 1'b1;
    end else begin
      for (int i = `ARB_NUM_REQ - 1; i >= 0; i--) begin
        if (r[i]) g = req_vec_t'(1) << i;
      end
    end
    return g;
  endfunction

  function automatic req_vec_t rr_expect(input req_vec_t last, input req_vec_t r);
    int       ptr;
    int       idx;
    req_vec_t g;
    ptr = 0;  // Idle grant counts as index 0
    g   = '0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (last[i]) ptr = i;
    end
    for (int k = 1; k <= `ARB_NUM_REQ; k++) begin
      idx = (ptr + k) % `ARB_NUM_REQ;
      if (r[idx] && g == '0) g[idx] = 1'b1;
    end
    return g;
  endfunction

  function automatic req_vec_t model_grant(input arb_type_t t, input req_vec_t r);
    case (t)
      `ARB_MODE_P0,
      `ARB_MODE_P1,
      `ARB_MODE_P2,
      `ARB_MODE_P3:   return prio_expect(int'(t), r);
      `ARB_MODE_RR:   return rr_expect(last_gnt, r);
      `ARB_MODE_RAND: return prio_expect(int'({m_s3, m_s2}), r);
      default:        return '0;
    endcase
  endfunction

  task automatic check_gnt(input req_vec_t expected, input req_vec_t actual);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("mismatch at %0t ns: gnt %b, expected %b (arb_type %0d, req %b)",
               $time, actual, expected, arb_type, req);
    end
  endtask

  task automatic check_onehot(input req_vec_t actual);
    check_cnt++;
    if ($countones(actual) > 1) begin
      err_cnt++;
      $display("mismatch at %0t ns: gnt %b has more than one bit set", $time, actual);
    end
  endtask

  task automatic check_subset(input req_vec_t sampled, input req_vec_t actual);
    check_cnt++;
    if ((actual & ~sampled) != '0) begin
      err_cnt++;
      $display("mismatch at %0t ns: gnt %b grants outside sampled req %b",
               $time, actual, sampled);
    end
  endtask

  task automatic add_row(input arb_type_t t, input req_vec_t r, input req_vec_t e,
                         input logic use_model);
    row_t row;
    row.t         = t;
    row.r         = r;
    row.e         = e;
    row.use_model = use_model;
    rows.push_back(row);
  endtask

  // Called just after a rising edge, checks after the next one
  task automatic apply_row(input row_t row);
    req_vec_t exp;
    arb_type = row.t;
    req      = row.r;
    if (row.use_model) exp = model_grant(row.t, row.r);
    else exp = row.e;
    #1;
    check_gnt(last_gnt, gnt);  // Previous grant holds until the edge
    @(posedge clk);
    #1;
    check_gnt(exp, gnt);
    check_onehot(gnt);
    check_subset(row.r, gnt);
    last_gnt = exp;
  endtask

  task automatic report_test(input string name, input int err_start);
    test_cnt++;
    if (err_cnt == err_start) begin
      $display("test %s: passed", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", name, err_cnt - err_start);
    end
  endtask

  task automatic run_table(input string name);
    int err_start;
    err_start = err_cnt;
    foreach (rows[i]) apply_row(rows[i]);
    rows.delete();
    report_test(name, err_start);
  endtask

  initial begin
    int   wait_cnt;
    int   code;
    int   pat;
    logic released;

    void'($urandom(32'h3dd5));
    req       = '0;
    arb_type  = '0;
    last_gnt  = '0;
    err_cnt   = 0;
    check_cnt = 0;
    test_cnt  = 0;
    fail_cnt  = 0;
    released  = 1'b0;

    // Grant stays zero in reset and on the first edge after release
    for (wait_cnt = 0; wait_cnt < 20 && !released; wait_cnt++) begin
      @(posedge clk);
      #1;
      check_gnt('0, gnt);
      released = rst_n;
    end

    if (!released) begin
      $display("timeout: reset still asserted after 20 clock cycles");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      report_test("reset", 0);

      for (code = 0; code < 4; code++) begin
        for (pat = 0; pat < 16; pat++) begin
          add_row(arb_type_t'(code), req_vec_t'(pat),
                  prio_expect(code, req_vec_t'(pat)), 1'b0);
        end
      end
      run_table("fixed_priority");

      add_row(`ARB_MODE_RR, 4'b0000, 4'b0000, 1'b0);  // Pointer back to 0
      add_row(`ARB_MODE_RR, 4'b1111, 4'b0010, 1'b0);
      add_row(`ARB_MODE_RR, 4'b1111, 4'b0100, 1'b0);
      add_row(`ARB_MODE_RR, 4'b1111, 4'b1000, 1'b0);
      add_row(`ARB_MODE_RR, 4'b1111, 4'b0001, 1'b0);
      add_row(`ARB_MODE_RR, 4'b1111, 4'b0010, 1'b0);
      add_row(`ARB_MODE_RR, 4'b0100, 4'b0100, 1'b0);
      add_row(`ARB_MODE_RR, 4'b0100, 4'b0100, 1'b0);  // Lone requester keeps it
      add_row(`ARB_MODE_RR, 4'b0101, 4'b0001, 1'b0);
      add_row(`ARB_MODE_RR, 4'b1010, 4'b0010, 1'b0);
      add_row(`ARB_MODE_RR, 4'b1001, 4'b1000, 1'b0);
      add_row(`ARB_MODE_RR, 4'b0011, 4'b0001, 1'b0);
      for (pat = 1; pat < 16; pat++) add_row(`ARB_MODE_RR, req_vec_t'(pat), '0, 1'b1);
      run_table("round_robin");

      // Two full LFSR periods with every requester active
      for (pat = 0; pat < 14; pat++) add_row(`ARB_MODE_RAND, 4'b1111, '0, 1'b1);
      for (pat = 1; pat < 16; pat++) add_row(`ARB_MODE_RAND, req_vec_t'(pat), '0, 1'b1);
      run_table("random_scheme");

      for (code = 0; code < 8; code++) add_row(arb_type_t'(code), 4'b0000, 4'b0000, 1'b0);
      add_row(3'd6, 4'b1111, 4'b0000, 1'b0);
      add_row(3'd7, 4'b1111, 4'b0000, 1'b0);
      add_row(3'd6, 4'b0101, 4'b0000, 1'b0);
      add_row(3'd7, 4'b1010, 4'b0000, 1'b0);
      run_table("invalid_idle");

      for (pat = 0; pat < 200; pat++) begin
        add_row(arb_type_t'($urandom % 8), req_vec_t'($urandom % 16), '0, 1'b1);
      end
      run_table("random_mix");

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               test_cnt, fail_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

/* verif/tb_clk_gen.sv */
//********************************************************************
// Testbench clock and reset
// 4 ns clock, reset held low for three rising edges and released
// on the following falling edge
//********************************************************************
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);  // Away from the sampling edge
    rst_n = 1'b1;
  end

endmodule
